//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ns
TOP = lcd_display_tb
FILELIST = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /RESULT: PASS/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- bench/lcd_bus_monitor.sv
`default_nettype none

module lcd_bus_monitor (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic [3:0]  lcd_data,
	input  wire logic        lcd_rs,
	input  wire logic        lcd_en,
	output logic             byte_valid,
	output logic      [7:0]  byte_value,
	output logic             byte_rs,
	output logic             glitch
);

	timeunit 1ns;
	timeprecision 1ns;

	logic en_q;
	logic [3:0] data_q;
	logic rs_q;
	logic [3:0] upper;
	logic have_upper;
	logic [2:0] single_count;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			en_q <= 1'b0;
			data_q <= '0;
			rs_q <= 1'b0;
			upper <= '0;
			have_upper <= 1'b0;
			single_count <= '0;
			byte_valid <= 1'b0;
			byte_value <= '0;
			byte_rs <= 1'b0;
			glitch <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			glitch <= 1'b0;
			en_q <= lcd_en;
			if (lcd_en) begin
				data_q <= lcd_data;
				rs_q <= lcd_rs;
				// Bus must hold still for the whole pulse
				if (en_q && (lcd_data != data_q || lcd_rs != rs_q)) begin
					glitch <= 1'b1;
				end
			end
			// EN just fell and the panel takes the latched nibble
			if (en_q && !lcd_en) begin
				if (single_count < 3'd4) begin
					single_count <= single_count + 3'd1;
					byte_value <= {4'h0, data_q};
					byte_rs <= rs_q;
					byte_valid <= 1'b1;
				end else if (!have_upper) begin
					upper <= data_q;
					have_upper <= 1'b1;
				end else begin
					have_upper <= 1'b0;
					byte_value <= {upper, data_q};
					byte_rs <= rs_q;
					byte_valid <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/lcd_display_tb.sv
`default_nettype none

module lcd_display_tb;

	timeunit 1ns;
	timeprecision 1ns;

	localparam int POWERUP_CYCLES = 20;
	localparam int EN_PULSE_CYCLES = 2;
	localparam int NIBBLE_GAP_CYCLES = 2;
	localparam int CMD_WAIT_CYCLES = 8;
	localparam int CLEAR_WAIT_CYCLES = 16;
	localparam int REFRESH_GAP_CYCLES = 30;
	localparam int AW = lcd_pkg::ADDR_W;
	localparam int CW = lcd_pkg::CHAR_W;

	// Worst case cycle counts for the timeout
	localparam int NIBBLE_TIME = EN_PULSE_CYCLES + 3;
	localparam int BYTE_TIME = 2 * NIBBLE_TIME + NIBBLE_GAP_CYCLES + CMD_WAIT_CYCLES + 1;
	localparam int INIT_TIME = POWERUP_CYCLES + 4 * (NIBBLE_TIME + CMD_WAIT_CYCLES + 1) +
		4 * BYTE_TIME + CLEAR_WAIT_CYCLES;
	localparam int FRAME_TIME = 34 * BYTE_TIME + REFRESH_GAP_CYCLES + 2;

	logic clk;
	logic reset;
	logic char_valid;
	logic char_ready;
	logic [AW-1:0] char_addr;
	logic [CW-1:0] char_data;
	logic [3:0] lcd_data;
	logic lcd_rs;
	logic lcd_rw;
	logic lcd_en;

	logic mon_valid;
	logic [7:0] mon_byte;
	logic mon_rs;
	logic mon_glitch;

	logic [CW-1:0] ref_text [lcd_pkg::TEXT_DEPTH];
	logic [AW-1:0] wr_addr_q [$];
	logic [CW-1:0] wr_data_q [$];
	int batch_len_q [$];
	int batch_frames_q [$];
	int init_count = 0;
	int frame_pos = 0;
	int frames_started = 0;
	int frames_done = 0;
	logic in_frame = 1'b0;
	int cycles = 0;
	int cycle_limit = 0;
	int stalled_writes = 0;

	lcd_display_top #(
		.POWERUP_CYCLES     (POWERUP_CYCLES),
		.EN_PULSE_CYCLES    (EN_PULSE_CYCLES),
		.NIBBLE_GAP_CYCLES  (NIBBLE_GAP_CYCLES),
		.CMD_WAIT_CYCLES    (CMD_WAIT_CYCLES),
		.CLEAR_WAIT_CYCLES  (CLEAR_WAIT_CYCLES),
		.REFRESH_GAP_CYCLES (REFRESH_GAP_CYCLES)
	) i_lcd_display_top (
		.clk        (clk),
		.reset      (reset),
		.char_valid (char_valid),
		.char_ready (char_ready),
		.char_addr  (char_addr),
		.char_data  (char_data),
		.lcd_data   (lcd_data),
		.lcd_rs     (lcd_rs),
		.lcd_rw     (lcd_rw),
		.lcd_en     (lcd_en)
	);

	lcd_bus_monitor i_lcd_bus_monitor (
		.clk         (clk),
		.reset       (reset),
		.lcd_data    (lcd_data),
		.lcd_rs      (lcd_rs),
		.lcd_en      (lcd_en),
		.byte_valid  (mon_valid),
		.byte_value  (mon_byte),
		.byte_rs     (mon_rs),
		.glitch      (mon_glitch)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// Wake nibbles, then function set, entry mode, display on, clear
	function automatic logic [7:0] init_byte(input int idx);
		case (idx)
			0, 1, 2: return 8'h03;
			3: return 8'h02;
			4: return 8'h28;
			5: return 8'h06;
			6: return 8'h0C;
			default: return 8'h01;
		endcase
	endfunction

	function automatic void frame_byte(input int pos, output logic [7:0] b, output logic r);
		if (pos == 0) begin
			b = 8'h80;
			r = 1'b0;
		end else if (pos <= 16) begin
			b = ref_text[AW'(pos - 1)];
			r = 1'b1;
		end else if (pos == 17) begin
			b = 8'hC0;
			r = 1'b0;
		end else begin
			b = ref_text[AW'(pos - 2)];
			r = 1'b1;
		end
	endfunction

	task automatic check_event(input logic [7:0] exp_byte, input logic exp_rs);
		assert (mon_byte == exp_byte) else report_failure($sformatf(
			"mismatch lcd_data byte: got %h expected %h", mon_byte, exp_byte));
		assert (mon_rs == exp_rs) else report_failure($sformatf(
			"mismatch lcd_rs: got %h expected %h", mon_rs, exp_rs));
	endtask

	task automatic write_char(input logic [AW-1:0] addr, input logic [CW-1:0] data);
		int idle;
		idle = $urandom_range(3, 0);
		repeat (idle) @(posedge clk);
		char_valid <= 1'b1;
		char_addr <= addr;
		char_data <= data;
		@(posedge clk);
		while (!char_ready) begin
			stalled_writes++;
			@(posedge clk);
		end
		char_valid <= 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reference text follows accepted handshakes only
	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < lcd_pkg::TEXT_DEPTH; i++) begin
				ref_text[AW'(i)] <= 8'h20;
			end
		end else if (char_valid && char_ready) begin
			ref_text[char_addr] <= char_data;
		end
	end

	always @(posedge clk) begin
		logic [7:0] exp_byte;
		logic exp_rs;
		if (!reset) begin
			assert (lcd_rw == 1'b0) else report_failure($sformatf(
				"mismatch lcd_rw: got %h expected %h", lcd_rw, 1'b0));
			assert (!mon_glitch) else report_failure(
				"lcd_data or lcd_rs changed while lcd_en was high");
			assert (!(in_frame && char_ready)) else report_failure(
				"char_ready was high while a frame was being drawn");
			if (mon_valid && init_count < 8) begin
				check_event(init_byte(init_count), 1'b0);
				init_count <= init_count + 1;
			end else if (mon_valid) begin
				frame_byte(frame_pos, exp_byte, exp_rs);
				check_event(exp_byte, exp_rs);
				if (frame_pos == 0) begin
					in_frame <= 1'b1;
					frames_started <= frames_started + 1;
				end
				if (frame_pos == 33) begin
					in_frame <= 1'b0;
					frames_done <= frames_done + 1;
					frame_pos <= 0;
				end else begin
					frame_pos <= frame_pos + 1;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		assert (cycles < cycle_limit) else report_failure($sformatf(
			"timeout after %0d cycles with %0d frames checked", cycles, frames_done));
	end

	initial begin
		int fd;
		int n;
		int frames;
		int count;
		int total_frames;
		int next_write;
		int base;
		string line;
		logic [AW-1:0] addr;
		logic [CW-1:0] data;
		void'($urandom(32'h622c_86d7));
		reset <= 1'b1;
		char_valid <= 1'b0;
		char_addr <= '0;
		char_data <= '0;
		count = 0;
		total_frames = 0;
		fd = $fopen("bench/lcd_stimulus.txt", "r");
		assert (fd != 0) else report_failure("could not open the stimulus file");
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) == "W") begin
				n = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, data);
				assert (n == 2) else report_failure("malformed write record in stimulus file");
				wr_addr_q.push_back(addr);
				wr_data_q.push_back(data);
				count++;
			end else if (line.len() > 1 && line.getc(0) == "F") begin
				n = $sscanf(line.substr(1, line.len() - 1), "%d", frames);
				assert (n == 1) else report_failure("malformed frame record in stimulus file");
				batch_len_q.push_back(count);
				batch_frames_q.push_back(frames);
				total_frames += frames;
				count = 0;
			end
		end
		$fclose(fd);
		assert (batch_len_q.size() > 0) else report_failure("stimulus file holds no records");
		// Each write can be held off by at most one frame
		cycle_limit = INIT_TIME + (total_frames + wr_addr_q.size() + 1) * FRAME_TIME + 200;

		repeat (3) @(posedge clk);
		reset <= 1'b0;

		next_write = 0;
		for (int b = 0; b < batch_len_q.size(); b++) begin
			for (int k = 0; k < batch_len_q[b]; k++) begin
				write_char(wr_addr_q[next_write], wr_data_q[next_write]);
				next_write++;
			end
			// Count only frames that begin after the batch
			base = frames_started;
			while (frames_done < base + batch_frames_q[b]) begin
				@(posedge clk);
			end
		end

		if (stalled_writes > 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			report_failure("no host write was ever held off by a frame");
		end
	end

endmodule

`default_nettype wire

//--- bench/lcd_stimulus.txt
# W <addr hex> <char hex>  host write into the text buffer
# F <count dec>  frames to check after the writes above
F 1
W 00 48
W 01 45
W 02 4C
W 03 4C
W 04 4F
F 2
W 10 57
W 11 4F
W 12 52
W 13 4C
W 14 44
W 0F 21
W 1F 3F
F 2
W 00 68
W 1F 2E
W 08 41
W 08 42
F 1
W 05 5F
F 2

//--- hw/lcd_control_unit.sv
`default_nettype none

module lcd_control_unit #(
	parameter int POWERUP_CYCLES = 750000,
	parameter int EN_PULSE_CYCLES = 12,
	parameter int NIBBLE_GAP_CYCLES = 50,
	parameter int CMD_WAIT_CYCLES = 2000,
	parameter int CLEAR_WAIT_CYCLES = 82000,
	parameter int REFRESH_GAP_CYCLES = 100000
) (
	input  wire logic                        clk,
	input  wire logic                        reset,
	output logic                             frame_busy,
	output logic      [lcd_pkg::ADDR_W-1:0]  read_addr,
	input  wire logic [lcd_pkg::CHAR_W-1:0]  read_data,
	output logic      [3:0]                  lcd_data,
	output logic                             lcd_rs,
	output logic                             lcd_en
);

	localparam int AW = lcd_pkg::ADDR_W;
	localparam int LONGEST = (POWERUP_CYCLES > REFRESH_GAP_CYCLES) ?
		POWERUP_CYCLES : REFRESH_GAP_CYCLES;
	localparam int CNT_W = $clog2(LONGEST + 1);

	typedef enum logic [2:0] {
		ST_POWERUP,
		ST_INIT,
		ST_ADDR,
		ST_CHAR,
		ST_FLUSH,
		ST_GAP
	} state_e;

	state_e state;
	lcd_pkg::lcd_inst_e instruction;
	logic [lcd_pkg::CHAR_W-1:0] operand;
	logic [CNT_W-1:0] cnt;
	logic [2:0] init_step;
	logic [AW-1:0] char_cnt;
	logic send_valid;
	logic send_ready;
	logic accepted;
	logic dec_rs;
	logic [lcd_pkg::CHAR_W-1:0] dec_byte;
	logic dec_nibble_only;

	// Wake nibbles, then the four setup commands
	function automatic lcd_pkg::lcd_inst_e init_inst(input logic [2:0] step);
		case (step)
			3'd3: return lcd_pkg::INST_WAKE4;
			3'd4: return lcd_pkg::INST_FUNC_SET;
			3'd5: return lcd_pkg::INST_ENTRY_MODE;
			3'd6: return lcd_pkg::INST_DISPLAY_ON;
			3'd7: return lcd_pkg::INST_CLEAR;
			default: return lcd_pkg::INST_WAKE;
		endcase
	endfunction

	assign accepted = send_valid && send_ready;
	assign read_addr = char_cnt;

	// The counter already points at the next character, so read_data is ready
	always_comb begin
		if (instruction == lcd_pkg::INST_WRITE_CHAR) begin
			operand = read_data;
		end else if (char_cnt >= AW'(lcd_pkg::LINE_LENGTH)) begin
			operand = lcd_pkg::LINE2_BASE;
		end else begin
			operand = '0;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_POWERUP;
			instruction <= lcd_pkg::INST_NONE;
			cnt <= CNT_W'(POWERUP_CYCLES - 1);
			init_step <= '0;
			char_cnt <= '0;
			send_valid <= 1'b0;
			frame_busy <= 1'b0;
		end else begin
			case (state)
				ST_POWERUP: begin
					if (cnt == '0) begin
						instruction <= init_inst(3'd0);
						send_valid <= 1'b1;
						state <= ST_INIT;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				ST_INIT: begin
					if (accepted) begin
						if (init_step == 3'd7) begin
							instruction <= lcd_pkg::INST_SET_ADDR;
							state <= ST_ADDR;
						end else begin
							init_step <= init_step + 1'b1;
							instruction <= init_inst(init_step + 1'b1);
						end
					end
				end
				ST_ADDR: begin
					if (accepted) begin
						if (char_cnt == '0) begin
							frame_busy <= 1'b1;
						end
						instruction <= lcd_pkg::INST_WRITE_CHAR;
						state <= ST_CHAR;
					end
				end
				ST_CHAR: begin
					if (accepted) begin
						char_cnt <= char_cnt + 1'b1;
						if (char_cnt == AW'(lcd_pkg::LINE_LENGTH - 1)) begin
							instruction <= lcd_pkg::INST_SET_ADDR;
							state <= ST_ADDR;
						end else if (char_cnt == AW'(lcd_pkg::TEXT_DEPTH - 1)) begin
							instruction <= lcd_pkg::INST_NONE;
							send_valid <= 1'b0;
							state <= ST_FLUSH;
						end
					end
				end
				// Last character still on its way out
				ST_FLUSH: begin
					if (send_ready) begin
						frame_busy <= 1'b0;
						cnt <= CNT_W'(REFRESH_GAP_CYCLES - 1);
						state <= ST_GAP;
					end
				end
				ST_GAP: begin
					if (cnt == '0) begin
						instruction <= lcd_pkg::INST_SET_ADDR;
						send_valid <= 1'b1;
						state <= ST_ADDR;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: begin
					state <= ST_POWERUP;
				end
			endcase
		end
	end

	lcd_inst_decode i_lcd_inst_decode (
		.instruction (instruction),
		.operand     (operand),
		.rs          (dec_rs),
		.cmd_byte    (dec_byte),
		.nibble_only (dec_nibble_only)
	);

	lcd_nibble_sender #(
		.EN_PULSE_CYCLES   (EN_PULSE_CYCLES),
		.NIBBLE_GAP_CYCLES (NIBBLE_GAP_CYCLES),
		.CMD_WAIT_CYCLES   (CMD_WAIT_CYCLES),
		.CLEAR_WAIT_CYCLES (CLEAR_WAIT_CYCLES)
	) i_lcd_nibble_sender (
		.clk         (clk),
		.reset       (reset),
		.send_valid  (send_valid),
		.send_ready  (send_ready),
		.rs          (dec_rs),
		.cmd_byte    (dec_byte),
		.nibble_only (dec_nibble_only),
		.lcd_data    (lcd_data),
		.lcd_rs      (lcd_rs),
		.lcd_en      (lcd_en)
	);

endmodule

`default_nettype wire

//--- hw/lcd_display_top.sv
`default_nettype none

module lcd_display_top #(
	// Defaults for a 50 MHz board clock
	parameter int POWERUP_CYCLES = 750000,
	parameter int EN_PULSE_CYCLES = 12,
	parameter int NIBBLE_GAP_CYCLES = 50,
	parameter int CMD_WAIT_CYCLES = 2000,
	parameter int CLEAR_WAIT_CYCLES = 82000,
	parameter int REFRESH_GAP_CYCLES = 100000
) (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        char_valid,
	output logic                             char_ready,
	input  wire logic [lcd_pkg::ADDR_W-1:0]  char_addr,
	input  wire logic [lcd_pkg::CHAR_W-1:0]  char_data,
	output logic      [3:0]                  lcd_data,
	output logic                             lcd_rs,
	output logic                             lcd_rw,
	output logic                             lcd_en
);

	logic frame_busy;
	logic [lcd_pkg::ADDR_W-1:0] read_addr;
	logic [lcd_pkg::CHAR_W-1:0] read_data;

	// Write-only panel
	assign lcd_rw = 1'b0;

	lcd_text_buffer i_lcd_text_buffer (
		.clk        (clk),
		.reset      (reset),
		.char_valid (char_valid),
		.char_ready (char_ready),
		.char_addr  (char_addr),
		.char_data  (char_data),
		.frame_busy (frame_busy),
		.read_addr  (read_addr),
		.read_data  (read_data)
	);

	lcd_control_unit #(
		.POWERUP_CYCLES     (POWERUP_CYCLES),
		.EN_PULSE_CYCLES    (EN_PULSE_CYCLES),
		.NIBBLE_GAP_CYCLES  (NIBBLE_GAP_CYCLES),
		.CMD_WAIT_CYCLES    (CMD_WAIT_CYCLES),
		.CLEAR_WAIT_CYCLES  (CLEAR_WAIT_CYCLES),
		.REFRESH_GAP_CYCLES (REFRESH_GAP_CYCLES)
	) i_lcd_control_unit (
		.clk        (clk),
		.reset      (reset),
		.frame_busy (frame_busy),
		.read_addr  (read_addr),
		.read_data  (read_data),
		.lcd_data   (lcd_data),
		.lcd_rs     (lcd_rs),
		.lcd_en     (lcd_en)
	);

endmodule

`default_nettype wire

//--- hw/lcd_inst_decode.sv
`default_nettype none

module lcd_inst_decode (
	input  wire lcd_pkg::lcd_inst_e          instruction,
	input  wire logic [lcd_pkg::CHAR_W-1:0]  operand,
	output logic                             rs,
	output logic      [lcd_pkg::CHAR_W-1:0]  cmd_byte,
	output logic                             nibble_only
);

	always_comb begin
		rs = 1'b0;
		cmd_byte = '0;
		nibble_only = 1'b0;
		case (instruction)
			// Wake-up codes only use the upper nibble
			lcd_pkg::INST_WAKE: begin
				cmd_byte = 8'h30;
				nibble_only = 1'b1;
			end
			lcd_pkg::INST_WAKE4: begin
				cmd_byte = 8'h20;
				nibble_only = 1'b1;
			end
			lcd_pkg::INST_FUNC_SET: begin
				cmd_byte = lcd_pkg::CMD_FUNC_SET;
			end
			lcd_pkg::INST_ENTRY_MODE: begin
				cmd_byte = lcd_pkg::CMD_ENTRY_MODE;
			end
			lcd_pkg::INST_DISPLAY_ON: begin
				cmd_byte = lcd_pkg::CMD_DISPLAY_ON;
			end
			lcd_pkg::INST_CLEAR: begin
				cmd_byte = lcd_pkg::CMD_CLEAR;
			end
			lcd_pkg::INST_SET_ADDR: begin
				cmd_byte = lcd_pkg::CMD_SET_ADDR_BIT | operand;
			end
			lcd_pkg::INST_WRITE_CHAR: begin
				rs = 1'b1;
				cmd_byte = operand;
			end
			default: begin
				cmd_byte = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/lcd_nibble_sender.sv
`default_nettype none

module lcd_nibble_sender #(
	parameter int EN_PULSE_CYCLES = 12,
	parameter int NIBBLE_GAP_CYCLES = 50,
	parameter int CMD_WAIT_CYCLES = 2000,
	parameter int CLEAR_WAIT_CYCLES = 82000
) (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        send_valid,
	output logic                             send_ready,
	input  wire logic                        rs,
	input  wire logic [lcd_pkg::CHAR_W-1:0]  cmd_byte,
	input  wire logic                        nibble_only,
	output logic      [3:0]                  lcd_data,
	output logic                             lcd_rs,
	output logic                             lcd_en
);

	localparam int LONG_STROBE = (EN_PULSE_CYCLES > NIBBLE_GAP_CYCLES) ?
		EN_PULSE_CYCLES : NIBBLE_GAP_CYCLES;
	localparam int LONG_WAIT = (CMD_WAIT_CYCLES > CLEAR_WAIT_CYCLES) ?
		CMD_WAIT_CYCLES : CLEAR_WAIT_CYCLES;
	localparam int LONGEST = (LONG_STROBE > LONG_WAIT) ? LONG_STROBE : LONG_WAIT;
	localparam int CNT_W = $clog2(LONGEST + 2);

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_SETUP,
		PH_PULSE,
		PH_HOLD,
		PH_GAP,
		PH_WAIT
	} phase_e;

	phase_e phase;
	logic [CNT_W-1:0] cnt;
	logic lower;
	logic rs_q;
	logic nibble_only_q;
	logic [lcd_pkg::CHAR_W-1:0] byte_q;
	logic is_clear;

	// Clear needs the long execution time
	assign is_clear = !rs_q && (byte_q == lcd_pkg::CMD_CLEAR);

	assign send_ready = (phase == PH_IDLE);
	assign lcd_en = (phase == PH_PULSE);
	assign lcd_rs = rs_q;
	assign lcd_data = lower ? byte_q[3:0] : byte_q[7:4];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= PH_IDLE;
			cnt <= '0;
			lower <= 1'b0;
			rs_q <= 1'b0;
			nibble_only_q <= 1'b0;
			byte_q <= '0;
		end else begin
			case (phase)
				PH_IDLE: begin
					if (send_valid) begin
						rs_q <= rs;
						byte_q <= cmd_byte;
						nibble_only_q <= nibble_only;
						lower <= 1'b0;
						cnt <= CNT_W'(1);
						phase <= PH_SETUP;
					end
				end
				PH_SETUP: begin
					if (cnt == '0) begin
						cnt <= CNT_W'(EN_PULSE_CYCLES - 1);
						phase <= PH_PULSE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				PH_PULSE: begin
					if (cnt == '0) begin
						phase <= PH_HOLD;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				PH_HOLD: begin
					if (!lower && !nibble_only_q) begin
						cnt <= CNT_W'(NIBBLE_GAP_CYCLES - 1);
						phase <= PH_GAP;
					end else begin
						cnt <= is_clear ? CNT_W'(CLEAR_WAIT_CYCLES - 1) :
							CNT_W'(CMD_WAIT_CYCLES - 1);
						phase <= PH_WAIT;
					end
				end
				PH_GAP: begin
					if (cnt == '0) begin
						lower <= 1'b1;
						cnt <= CNT_W'(1);
						phase <= PH_SETUP;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				PH_WAIT: begin
					if (cnt == '0) begin
						phase <= PH_IDLE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: begin
					phase <= PH_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	// Instruction codes between the sequencer and the decoder
	typedef enum logic [3:0] {
		INST_WAKE       = 4'd0,
		INST_WAKE4      = 4'd1,
		INST_FUNC_SET   = 4'd2,
		INST_ENTRY_MODE = 4'd3,
		INST_DISPLAY_ON = 4'd4,
		INST_CLEAR      = 4'd5,
		INST_SET_ADDR   = 4'd6,
		INST_WRITE_CHAR = 4'd7,
		INST_NONE       = 4'd15
	} lcd_inst_e;

	localparam int TEXT_DEPTH = 32;
	localparam int LINE_LENGTH = 16;
	localparam int ADDR_W = $clog2(TEXT_DEPTH);
	localparam int CHAR_W = 8;

	// DDRAM start of the second line
	localparam logic [CHAR_W-1:0] LINE2_BASE = 8'h40;

	// 4-bit bus, two lines, 5x8 font
	localparam logic [CHAR_W-1:0] CMD_FUNC_SET = 8'h28;
	localparam logic [CHAR_W-1:0] CMD_ENTRY_MODE = 8'h06;
	localparam logic [CHAR_W-1:0] CMD_DISPLAY_ON = 8'h0C;
	localparam logic [CHAR_W-1:0] CMD_CLEAR = 8'h01;
	localparam logic [CHAR_W-1:0] CMD_SET_ADDR_BIT = 8'h80;

endpackage

`default_nettype wire

//--- hw/lcd_text_buffer.sv
`default_nettype none

module lcd_text_buffer (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        char_valid,
	output logic                             char_ready,
	input  wire logic [lcd_pkg::ADDR_W-1:0]  char_addr,
	input  wire logic [lcd_pkg::CHAR_W-1:0]  char_data,
	input  wire logic                        frame_busy,
	input  wire logic [lcd_pkg::ADDR_W-1:0]  read_addr,
	output logic      [lcd_pkg::CHAR_W-1:0]  read_data
);

	logic [lcd_pkg::CHAR_W-1:0] mem [lcd_pkg::TEXT_DEPTH];

	// Host is held off for the whole frame
	assign char_ready = !frame_busy;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			// Blank screen after reset
			for (int i = 0; i < lcd_pkg::TEXT_DEPTH; i++) begin
				mem[i] <= 8'h20;
			end
		end else if (char_valid && char_ready) begin
			mem[char_addr] <= char_data;
		end
	end

	always_ff @(posedge clk) begin
		read_data <= mem[read_addr];
	end

endmodule

`default_nettype wire

//--- list.f
hw/lcd_pkg.sv
hw/lcd_text_buffer.sv
hw/lcd_inst_decode.sv
hw/lcd_nibble_sender.sv
hw/lcd_control_unit.sv
hw/lcd_display_top.sv
bench/lcd_bus_monitor.sv
bench/lcd_display_tb.sv
